//--- hdl/scan_config.svh
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Stream id width, enough for 64 interleaved streams
`define SCAN_STREAM_ID_W 6

// Depth of the per-stream DFA state memory
`define SCAN_STREAMS 64

// DFA state width
// States 0 to 6 are used, the rest are unreachable
`define SCAN_STATE_W 4

// Width of the match and packet counters
`define SCAN_COUNT_W 16

// Cycles from pkt_end until the DFA result for the last byte is registered
// Covers the DFA input register, the DFA itself and the output register
`define SCAN_DRAIN 3

`endif

//--- hdl/scan_pkg.sv
`include "scan_config.svh"

package scan_pkg;

  // One byte of packet payload
  typedef logic [7:0] char_t;

  // Stream id carried with pkt_start
  typedef logic [`SCAN_STREAM_ID_W-1:0] stream_id_t;

  // DFA state as saved and restored per stream
  typedef logic [`SCAN_STATE_W-1:0] dfa_state_t;

  // Packet counter value, wraps on overflow
  typedef logic [`SCAN_COUNT_W-1:0] count_t;

  // Packet sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    PRIME,
    SCAN,
    DRAIN,
    FINISH
  } seq_state_t;

endpackage

//--- hdl/sig_dfa.sv
module sig_dfa (
  input  logic               clk,
  input  logic               rst_n,
  input  scan_pkg::char_t    char_in,
  input  logic               char_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic               state_in_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic               accept
);

  import scan_pkg::*;

  // State 6 means the whole of "public" was seen
  localparam dfa_state_t ACCEPT_ST = dfa_state_t'(6);

  dfa_state_t next_st;

  // One step of the DFA for the "public" signature
  function automatic dfa_state_t dfa_step(dfa_state_t cur, char_t c);
    char_t want;
    dfa_state_t nxt;
    // Character expected in each partial-match state
    case (cur)
      dfa_state_t'(0): want = "p";
      dfa_state_t'(1): want = "u";
      dfa_state_t'(2): want = "b";
      dfa_state_t'(3): want = "l";
      dfa_state_t'(4): want = "i";
      dfa_state_t'(5): want = "c";
      // Accept state and unused codes restart the search
      default:         want = "p";
    endcase
    if (cur < ACCEPT_ST && c == want)
    begin
      nxt = cur + dfa_state_t'(1);
    end
    // A stray 'p' may still start a new match
    else if (c == "p")
    begin
      nxt = dfa_state_t'(1);
    end
    else
    begin
      nxt = '0;
    end
    return nxt;
  endfunction

  assign next_st = dfa_step(state_out, char_in);

  // State register
  // A restore from the context memory wins over a byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= '0;
      accept    <= 1'b0;
    end
    else if (state_in_vld)
    begin
      state_out <= state_in;
      accept    <= 1'b0;
    end
    else if (char_vld)
    begin
      state_out <= next_st;
      // Pulse once for each entry into the accept state
      accept    <= (next_st == ACCEPT_ST);
    end
    else
    begin
      accept <= 1'b0;
    end
  end

endmodule

//--- hdl/stream_context.sv
`include "scan_config.svh"

module stream_context (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 save,
  input  logic                 scan,
  input  logic                 new_stream,
  input  logic                 enable,
  input  logic                 char_vld,
  input  scan_pkg::stream_id_t stream_id,
  input  scan_pkg::char_t      char_in,
  output logic                 fired,
  output logic                 packet_hit
);

  import scan_pkg::*;

  // Saved DFA state, one entry per stream
  dfa_state_t state_mem [`SCAN_STREAMS];

  // Restore stage, filled from memory on load
  dfa_state_t state_in;
  logic       state_in_vld;

  // DFA input registers
  char_t      char_in_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_in_vld_r;

  // DFA outputs, raw and registered
  dfa_state_t state_out;
  logic       accept_out;
  dfa_state_t state_out_r;
  logic       accept_out_r;

  // Set once the signature has been seen in the current packet
  logic match_flag;

  // Save and restore of the per-stream state
  always_ff @(posedge clk)
  begin
    // Disabled packets leave the stored state alone
    if (save && enable)
      state_mem[stream_id] <= state_out_r;
    if (load)
      // A new stream starts the search from scratch
      state_in <= new_stream ? '0 : state_mem[stream_id];
  end

  // Data side of the DFA pipeline
  always_ff @(posedge clk)
  begin
    char_in_r   <= char_in;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Strobe side of the DFA pipeline
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld   <= 1'b0;
      state_in_vld_r <= 1'b0;
      char_vld_r     <= 1'b0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      state_in_vld   <= load;
      state_in_vld_r <= state_in_vld;
      // Bytes outside the scan window are dropped here
      char_vld_r     <= char_vld && scan;
      accept_out_r   <= accept_out;
    end
  end

  // Match flag per packet and the reported result
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      match_flag <= 1'b0;
      fired      <= 1'b0;
    end
    else
    begin
      if (load)
        match_flag <= 1'b0;
      else if (accept_out_r)
        match_flag <= 1'b1;
      // Result held from done until the next packet loads
      if (load)
        fired <= 1'b0;
      else if (save)
        fired <= match_flag;
    end
  end

  // Flag as it stands when the sequencer saves
  assign packet_hit = match_flag;

  sig_dfa sig_dfa_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept       (accept_out)
  );

  // Only one packet in flight, so restore and save never overlap
  load_save_excl: assert property (@(posedge clk) disable iff (!rst_n) !(load && save))
    else $error("load and save in the same cycle");

endmodule

//--- hdl/packet_sequencer.sv
`include "scan_config.svh"

module packet_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pkt_start,
  input  logic                 pkt_end,
  input  scan_pkg::stream_id_t stream_id_in,
  input  logic                 new_stream_in,
  input  logic                 enable_in,
  output scan_pkg::stream_id_t stream_id,
  output logic                 new_stream,
  output logic                 enable,
  output logic                 load,
  output logic                 scan,
  output logic                 save,
  output logic                 done
);

  import scan_pkg::*;

  localparam int DRAIN_W = $clog2(`SCAN_DRAIN + 1);

  seq_state_t         state;
  seq_state_t         state_nxt;
  logic [DRAIN_W-1:0] drain_cnt;

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:    if (pkt_start) state_nxt = LOAD;
      LOAD:    state_nxt = PRIME;
      // Restored state still travelling to the DFA
      PRIME:   state_nxt = SCAN;
      SCAN:    if (pkt_end) state_nxt = DRAIN;
      DRAIN:   if (drain_cnt == '0) state_nxt = FINISH;
      FINISH:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      drain_cnt <= '0;
      done      <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      // Wait for the last byte to clear the DFA pipeline
      if (state == SCAN && pkt_end)
        drain_cnt <= DRAIN_W'(`SCAN_DRAIN - 1);
      else if (state == DRAIN && drain_cnt != '0)
        drain_cnt <= drain_cnt - DRAIN_W'(1);
      done <= (state == FINISH);
    end
  end

  // Packet attributes, held for the whole packet
  always_ff @(posedge clk)
  begin
    if (state == IDLE && pkt_start)
    begin
      stream_id  <= stream_id_in;
      new_stream <= new_stream_in;
      enable     <= enable_in;
    end
  end

  assign load = (state == LOAD);
  assign scan = (state == SCAN);
  assign save = (state == FINISH);

  // No byte window during the drain, then done closes the packet
  drain_window: assert property (@(posedge clk) disable iff (!rst_n)
    scan && pkt_end |=> (!scan [* (`SCAN_DRAIN + 1)]) ##1 done)
    else $error("scan window or done out of step after pkt_end");

endmodule

//--- hdl/match_counter.sv
module match_counter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             save,
  input  logic             enable,
  input  logic             packet_hit,
  output scan_pkg::count_t match_count,
  output scan_pkg::count_t pkt_count
);

  import scan_pkg::*;

  // Only enabled packets are counted
  logic count_en;

  assign count_en = save && enable;

  // Both counters wrap silently
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      match_count <= '0;
      pkt_count   <= '0;
    end
    else if (count_en)
    begin
      // Hit adds one, a clean packet adds nothing
      match_count <= match_count + count_t'(packet_hit);
      pkt_count   <= pkt_count + count_t'(1);
    end
  end

endmodule

//--- hdl/sig_scan_top.sv
module sig_scan_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pkt_start,
  input  scan_pkg::stream_id_t stream_id,
  input  logic                 new_stream,
  input  logic                 enable,
  input  scan_pkg::char_t      char_in,
  input  logic                 char_vld,
  input  logic                 pkt_end,
  output logic                 ready,
  output logic                 done,
  output logic                 fired,
  output scan_pkg::count_t     match_count,
  output scan_pkg::count_t     pkt_count
);

  import scan_pkg::*;

  // Attributes latched by the sequencer at pkt_start
  stream_id_t seq_stream_id;
  logic       seq_new_stream;
  logic       seq_enable;

  // Sequencer strobes
  logic load;
  logic scan;
  logic save;

  // Match result handed to the counters at save
  logic packet_hit;

  // Bytes are accepted exactly while the scan window is open
  assign ready = scan;

  packet_sequencer packet_sequencer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkt_start     (pkt_start),
    .pkt_end       (pkt_end),
    .stream_id_in  (stream_id),
    .new_stream_in (new_stream),
    .enable_in     (enable),
    .stream_id     (seq_stream_id),
    .new_stream    (seq_new_stream),
    .enable        (seq_enable),
    .load          (load),
    .scan          (scan),
    .save          (save),
    .done          (done)
  );

  stream_context stream_context_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .save       (save),
    .scan       (scan),
    .new_stream (seq_new_stream),
    .enable     (seq_enable),
    .char_vld   (char_vld),
    .stream_id  (seq_stream_id),
    .char_in    (char_in),
    .fired      (fired),
    .packet_hit (packet_hit)
  );

  match_counter match_counter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .save        (save),
    .enable      (seq_enable),
    .packet_hit  (packet_hit),
    .match_count (match_count),
    .pkt_count   (pkt_count)
  );

endmodule

//--- tb/sig_scan_tb.sv
`include "scan_config.svh"

module sig_scan_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import scan_pkg::*;

  // Run budget of 40 cycles per packet plus every byte sent
  localparam int DIR_PKTS  = 13;
  localparam int DIR_BYTES = 62;
  localparam int RND_PKTS  = 24;
  localparam int RND_MAX   = 14;
  localparam int LIMIT     = 40 * (DIR_PKTS + RND_PKTS) + DIR_BYTES + RND_PKTS * RND_MAX;

  logic       clk;
  logic       rst_n;
  logic       pkt_start;
  stream_id_t stream_id;
  logic       new_stream;
  logic       enable;
  char_t      char_in;
  logic       char_vld;
  logic       pkt_end;
  logic       ready;
  logic       done;
  logic       fired;
  count_t     match_count;
  count_t     pkt_count;

  // Reference model keeps the saved DFA state and a written flag per stream
  dfa_state_t ref_state [`SCAN_STREAMS];
  logic       ref_valid [`SCAN_STREAMS];
  count_t     ref_match;
  count_t     ref_pkts;

  // Payload of the next packet
  char_t       pkt_bytes [$];
  logic [31:0] lfsr;
  int          cycles = 0;
  int          errors;
  int          checks;
  int          tests;

  sig_scan_top sig_scan_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt_start   (pkt_start),
    .stream_id   (stream_id),
    .new_stream  (new_stream),
    .enable      (enable),
    .char_in     (char_in),
    .char_vld    (char_vld),
    .pkt_end     (pkt_end),
    .ready       (ready),
    .done        (done),
    .fired       (fired),
    .match_count (match_count),
    .pkt_count   (pkt_count)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Stop a hung run
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] val;
    logic       fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[6:0], fb};
    end
    return val;
  endfunction

  // Expected search advances on the next signature char
  // Any other byte restarts at 1 on 'p' or at 0
  function automatic dfa_state_t model_step(input dfa_state_t st, input char_t c);
    string sig;
    sig = "public";
    if (st < dfa_state_t'(6) && c == sig[st])
      return st + dfa_state_t'(1);
    return (c == "p") ? dfa_state_t'(1) : dfa_state_t'(0);
  endfunction

  // Predict one packet
  // Only enabled packets save state and count
  function automatic logic model_packet(input stream_id_t sid, input logic ns, input logic en);
    dfa_state_t st;
    logic       hit;
    st  = ns ? '0 : ref_state[sid];
    hit = 1'b0;
    foreach (pkt_bytes[i])
    begin
      st  = model_step(st, pkt_bytes[i]);
      hit = hit | (st == dfa_state_t'(6));
    end
    if (en)
    begin
      ref_state[sid] = st;
      ref_valid[sid] = 1'b1;
      ref_match      = ref_match + count_t'(hit);
      ref_pkts       = ref_pkts + count_t'(1);
    end
    return hit;
  endfunction

  task automatic check_bit(input logic exp, input logic got, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s expected %0b got %0b", $time, what, exp, got);
    end
  endtask

  task automatic check_count(input count_t exp, input count_t got, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic add_bytes(input string s);
    for (int i = 0; i < s.len(); i++)
      pkt_bytes.push_back(s[i]);
  endtask

  // Start the packet and stream bytes while ready is high
  // then end it and wait for done
  task automatic send_packet(input stream_id_t sid, input logic ns, input logic en);
    @(posedge clk);
    pkt_start  <= 1'b1;
    stream_id  <= sid;
    new_stream <= ns;
    enable     <= en;
    @(posedge clk);
    pkt_start <= 1'b0;
    while (!ready)
      @(posedge clk);
    // Last byte shares its cycle with pkt_end
    foreach (pkt_bytes[i])
    begin
      char_in  <= pkt_bytes[i];
      char_vld <= 1'b1;
      pkt_end  <= (i == pkt_bytes.size() - 1);
      @(posedge clk);
    end
    // An empty packet sends pkt_end alone
    if (pkt_bytes.size() == 0)
    begin
      pkt_end <= 1'b1;
      @(posedge clk);
    end
    char_vld <= 1'b0;
    pkt_end  <= 1'b0;
    while (!done)
      @(posedge clk);
  endtask

  // Send the queued bytes and compare fired and counts with the model
  task automatic packet_check(input stream_id_t sid, input logic ns, input logic en);
    logic exp_hit;
    exp_hit = model_packet(sid, ns, en);
    send_packet(sid, ns, en);
    check_bit(exp_hit, fired, "fired");
    check_count(ref_match, match_count, "match_count");
    check_count(ref_pkts, pkt_count, "pkt_count");
    pkt_bytes.delete();
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before)
      $display("Test %s: ok", name);
    else
      $display("Test %s: FAILED with %0d errors", name, errors - errs_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(posedge clk);
    check_bit(1'b0, ready, "ready after reset");
    check_bit(1'b0, done, "done after reset");
    check_bit(1'b0, fired, "fired after reset");
    check_count(count_t'(0), match_count, "match_count after reset");
    check_count(count_t'(0), pkt_count, "pkt_count after reset");
    end_test("reset values", e0);
  endtask

  task automatic test_single();
    int e0;
    e0 = errors;
    add_bytes("getpublicx");
    packet_check(6'd5, 1'b1, 1'b1);
    check_bit(1'b1, fired, "fired on public");
    check_count(count_t'(1), match_count, "match_count after hit");
    add_bytes("pubxlic");
    packet_check(6'd5, 1'b0, 1'b1);
    check_bit(1'b0, fired, "fired on broken signature");
    // Only the packet count moves on a clean packet
    check_count(count_t'(1), match_count, "match_count after clean packet");
    check_count(count_t'(2), pkt_count, "pkt_count after clean packet");
    end_test("single packet", e0);
  endtask

  task automatic test_split();
    int e0;
    e0 = errors;
    add_bytes("abcpub");
    packet_check(6'd12, 1'b1, 1'b1);
    add_bytes("licz");
    packet_check(6'd12, 1'b0, 1'b1);
    check_bit(1'b1, fired, "split signature on second packet");
    add_bytes("zzpub");
    packet_check(6'd12, 1'b1, 1'b1);
    // New stream flag throws away the partial match
    add_bytes("licz");
    packet_check(6'd12, 1'b1, 1'b1);
    check_bit(1'b0, fired, "split signature after new stream");
    end_test("split signature", e0);
  endtask

  task automatic test_interleave();
    int e0;
    e0 = errors;
    add_bytes("zz");
    packet_check(6'd9, 1'b1, 1'b1);
    add_bytes("xpu");
    packet_check(6'd3, 1'b1, 1'b1);
    // Stream 9 must not pick up the partial match of stream 3
    add_bytes("blic");
    packet_check(6'd9, 1'b0, 1'b1);
    check_bit(1'b0, fired, "tail on stream 9");
    add_bytes("blic");
    packet_check(6'd3, 1'b0, 1'b1);
    check_bit(1'b1, fired, "tail on stream 3");
    end_test("interleaved streams", e0);
  endtask

  task automatic test_disabled();
    int     e0;
    count_t m0;
    count_t p0;
    e0 = errors;
    add_bytes("qpub");
    packet_check(6'd20, 1'b1, 1'b1);
    // Model counts before the disabled packet
    m0 = ref_match;
    p0 = ref_pkts;
    // Disabled packet still reports its own hit
    add_bytes("public");
    packet_check(6'd20, 1'b0, 1'b0);
    check_bit(1'b1, fired, "fired on disabled packet");
    check_count(m0, match_count, "match_count after disabled packet");
    check_count(p0, pkt_count, "pkt_count after disabled packet");
    add_bytes("lic");
    packet_check(6'd20, 1'b0, 1'b1);
    check_bit(1'b1, fired, "tail after disabled packet");
    end_test("disabled packet", e0);
  endtask

  task automatic test_random();
    int         e0;
    int         chunks;
    logic [7:0] r;
    stream_id_t sid;
    logic       ns;
    logic       en;
    stream_id_t pool [4];
    e0   = errors;
    pool = '{6'd3, 6'd9, 6'd40, 6'd63};
    for (int p = 0; p < RND_PKTS; p++)
    begin
      r   = take_bits(2);
      sid = pool[r[1:0]];
      // Streams never saved must start as new
      r   = take_bits(3);
      ns  = !ref_valid[sid] || (r == 8'd0);
      r   = take_bits(3);
      en  = (r != 8'd0);
      r   = take_bits(3);
      chunks = int'(r[2:0]);
      // Signature chunks make hits and splits likely
      for (int c = 0; c < chunks; c++)
      begin
        r = take_bits(2);
        case (r[1:0])
          2'd0: pkt_bytes.push_back(take_bits(8));
          2'd1: add_bytes("pu");
          2'd2: add_bytes("bl");
          2'd3: add_bytes("ic");
        endcase
      end
      packet_check(sid, ns, en);
    end
    end_test("random traffic", e0);
  endtask

  initial
  begin
    errors     = 0;
    checks     = 0;
    tests      = 0;
    lfsr       = 32'h822c;
    ref_match  = '0;
    ref_pkts   = '0;
    foreach (ref_valid[i])
    begin
      ref_valid[i] = 1'b0;
      ref_state[i] = '0;
    end
    rst_n      = 1'b0;
    pkt_start  = 1'b0;
    stream_id  = '0;
    new_stream = 1'b0;
    enable     = 1'b0;
    char_in    = '0;
    char_vld   = 1'b0;
    pkt_end    = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_single();
    test_split();
    test_interleave();
    test_disabled();
    test_random();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/scan_pkg.sv
hdl/sig_dfa.sv
hdl/stream_context.sv
hdl/packet_sequencer.sv
hdl/match_counter.sv
hdl/sig_scan_top.sv
tb/sig_scan_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the signature scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  -f verilog.f --top-module sig_scan_tb -Mdir obj_dir

status=0
./obj_dir/Vsig_scan_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
